// File: design/calc_arith_pkg.sv
package calc_arith_pkg;

    // One-hot operator code from the keypad
    typedef logic [2:0] op_t;

    localparam op_t OP_ADD = 3'b001;     // Lowest bit
    localparam op_t OP_SUB = 3'b010;     // Middle bit
    localparam op_t OP_MUL = 3'b100;     // Top bit

    // Bits handled by the add/sub unit in one cycle
    localparam int ADD_SLICE = 4;

    // Unit latencies for the default 16-bit word.
    // The units derive their own counts from WIDTH and compare against these at 16
    localparam int ADD_STEPS = 4;        // Slices per 16-bit word
    localparam int MUL_STEPS = 16;       // Shift-add iterations per 16-bit word

endpackage

// File: design/calc_key_pkg.sv
package calc_key_pkg;

    // Keypad digit code
    localparam int KEY_W = 4;

    // Codes above this are not digits
    localparam int MAX_DIGIT = 9;

    // Each appended digit scales the operand by this
    localparam int RADIX = 10;

endpackage

// File: design/add_sub_unit.sv
`timescale 1ns/1ps

module add_sub_unit #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             sub,
    input  logic             start,
    output logic [WIDTH-1:0] result,
    output logic             finish
);
    import calc_arith_pkg::*;

    localparam int STEPS = WIDTH / ADD_SLICE;
    localparam int CNT_W = $clog2(STEPS + 1);

    if (WIDTH == 16 && STEPS != ADD_STEPS) begin : g_steps_check
        $error("add_sub_unit slice count differs from ADD_STEPS");
    end

    logic                 running;
    logic [CNT_W-1:0]     count;
    logic [WIDTH-1:0]     a_sh;
    logic [WIDTH-1:0]     b_sh;
    logic [WIDTH-1:0]     b_eff;
    logic                 carry;
    logic [ADD_SLICE-1:0] a_slice;
    logic [ADD_SLICE-1:0] b_slice;
    logic                 carry_in;
    logic [ADD_SLICE:0]   slice_sum;

    assign b_eff = sub ? ~b : b;                // Two's complement via inverted b plus carry

    // Slice 0 is added in the start cycle, so the run takes STEPS edges
    always_comb begin
        a_slice   = start ? a[ADD_SLICE-1:0] : a_sh[ADD_SLICE-1:0];
        b_slice   = start ? b_eff[ADD_SLICE-1:0] : b_sh[ADD_SLICE-1:0];
        carry_in  = start ? sub : carry;
        slice_sum = {1'b0, a_slice} + {1'b0, b_slice} + {{ADD_SLICE{1'b0}}, carry_in};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            count   <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= CNT_W'(1);           // First slice done on this edge
            end else if (running) begin
                count <= count + 1'b1;
                if (count == CNT_W'(STEPS - 1)) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_sh <= a >> ADD_SLICE;
            b_sh <= b_eff >> ADD_SLICE;
        end else if (running) begin
            a_sh <= a_sh >> ADD_SLICE;
            b_sh <= b_sh >> ADD_SLICE;
        end
        if (start || running) begin
            carry  <= slice_sum[ADD_SLICE];
            result <= {slice_sum[ADD_SLICE-1:0], result[WIDTH-1:ADD_SLICE]};  // Fill from the top
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !running);

    a_finish_latency: assert property (@(posedge clk) disable iff (!nRST)
        start |-> ##STEPS finish);

endmodule

// File: design/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier #(
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             start,
    output logic [WIDTH-1:0] result,
    output logic             finish
);
    import calc_arith_pkg::*;

    localparam int STEPS = WIDTH;               // One iteration per multiplier bit
    localparam int CNT_W = $clog2(STEPS + 1);

    if (WIDTH == 16 && STEPS != MUL_STEPS) begin : g_steps_check
        $error("shift_add_multiplier iteration count differs from MUL_STEPS");
    end

    logic             running;
    logic [CNT_W-1:0] count;
    logic             last_step;
    logic [WIDTH-1:0] mcand;
    logic [WIDTH-1:0] mplier;
    logic [WIDTH-1:0] acc;
    logic [WIDTH-1:0] acc_next;

    assign last_step = running && (count == CNT_W'(STEPS - 1));

    // Upper product bits fall off the shifted multiplicand
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            count   <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                running <= 1'b1;                // Load cycle
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            acc    <= acc_next;
            if (last_step) begin
                result <= acc_next;             // Held until the next run ends
            end
        end
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !running);

    a_finish_pulse: assert property (@(posedge clk) disable iff (!nRST)
        finish |=> !finish);

    // Load edge plus one edge per bit
    a_finish_latency: assert property (@(posedge clk) disable iff (!nRST)
        start |-> ##(STEPS + 1) finish);

endmodule

// File: design/calc_controller.sv
`timescale 1ns/1ps

module calc_controller #(
    parameter int WIDTH = 16
) (
    input  logic                             clk,
    input  logic                             nRST,
    input  logic [calc_key_pkg::KEY_W-1:0]   keypad_input,
    input  logic                             read_input,
    input  calc_arith_pkg::op_t              operator_input,
    input  logic                             equal_input,
    output logic                             busy,
    output logic                             complete,
    output logic [WIDTH-1:0]                 display_output,
    output logic [WIDTH-1:0]                 alu_a,
    output logic [WIDTH-1:0]                 alu_b,
    output logic                             alu_sub,
    output logic                             alu_start,
    input  logic [WIDTH-1:0]                 alu_result,
    input  logic                             alu_finish,
    output logic [WIDTH-1:0]                 mul_a,
    output logic [WIDTH-1:0]                 mul_b,
    output logic                             mul_start,
    input  logic [WIDTH-1:0]                 mul_result,
    input  logic                             mul_finish
);
    import calc_arith_pkg::*;
    import calc_key_pkg::*;

    typedef enum logic [2:0] {
        ST_ENTRY  = 3'd0,   // Waiting for keys
        ST_SCALE  = 3'd1,   // Operand times RADIX on the multiplier
        ST_APPEND = 3'd2,   // Digit added on the add/sub unit
        ST_CALC   = 3'd3,   // Final operation running
        ST_SHOW   = 3'd4    // Result cycle, also accepts keys
    } state_t;

    state_t           state;
    logic [WIDTH-1:0] operand1;
    logic [WIDTH-1:0] operand2;
    op_t              op_q;
    logic             second;          // Entering operand 2
    logic [KEY_W-1:0] digit_q;

    logic             idle;
    logic             op_valid;
    logic             digit_valid;
    logic             take_equal;
    logic             take_op;
    logic             take_digit;
    logic             calc_finish;
    logic [WIDTH-1:0] calc_result;

    assign idle     = (state == ST_ENTRY) || (state == ST_SHOW);
    assign busy     = !idle;
    assign complete = (state == ST_SHOW);

    assign op_valid    = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                         (operator_input == OP_MUL);
    assign digit_valid = read_input && (keypad_input <= KEY_W'(MAX_DIGIT));

    // Priority equal, operator, read; a strobe that would be ignored does not block the others
    assign take_equal = idle && equal_input && second;
    assign take_op    = idle && !take_equal && op_valid;
    assign take_digit = idle && !take_equal && !op_valid && digit_valid;

    // Only the unit started for the latched operator is watched
    assign calc_finish = (op_q == OP_MUL) ? mul_finish : alu_finish;
    assign calc_result = (op_q == OP_MUL) ? mul_result : alu_result;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ST_ENTRY;
            operand1       <= '0;
            operand2       <= '0;
            op_q           <= OP_ADD;
            second         <= 1'b0;
            display_output <= '0;
            alu_start      <= 1'b0;
            mul_start      <= 1'b0;
        end else begin
            alu_start <= 1'b0;
            mul_start <= 1'b0;
            case (state)
                ST_ENTRY, ST_SHOW: begin
                    state <= ST_ENTRY;
                    if (take_equal) begin
                        state <= ST_CALC;
                        if (op_q == OP_MUL) begin
                            mul_start <= 1'b1;
                        end else begin
                            alu_start <= 1'b1;
                        end
                    end else if (take_op) begin
                        op_q   <= operator_input;  // A later operator just replaces it
                        second <= 1'b1;
                    end else if (take_digit) begin
                        state     <= ST_SCALE;
                        mul_start <= 1'b1;
                    end
                end
                ST_SCALE: begin
                    if (mul_finish) begin
                        state     <= ST_APPEND;
                        alu_start <= 1'b1;
                    end
                end
                ST_APPEND: begin
                    if (alu_finish) begin
                        state <= ST_ENTRY;
                        if (second) begin
                            operand2 <= alu_result;
                        end else begin
                            operand1 <= alu_result;
                        end
                    end
                end
                ST_CALC: begin
                    if (calc_finish) begin
                        state          <= ST_SHOW;
                        display_output <= calc_result;
                        operand1       <= '0;          // Next entry starts fresh
                        operand2       <= '0;
                        second         <= 1'b0;
                    end
                end
                default: state <= ST_ENTRY;
            endcase
        end
    end

    // Unit operands, stable while the unit runs
    always_ff @(posedge clk) begin
        if (take_equal) begin
            alu_a   <= operand1;
            alu_b   <= operand2;
            alu_sub <= (op_q == OP_SUB);
            mul_a   <= operand1;
            mul_b   <= operand2;
        end
        if (take_digit) begin
            digit_q <= keypad_input;
            mul_a   <= second ? operand2 : operand1;
            mul_b   <= WIDTH'(RADIX);
        end
        if ((state == ST_SCALE) && mul_finish) begin
            alu_a   <= mul_result;                     // Scaled operand
            alu_b   <= WIDTH'(digit_q);
            alu_sub <= 1'b0;
        end
    end

    a_complete_pulse: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete);

    a_one_unit: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mul_start));

    // A finish from the adder is only expected while waiting on it
    a_alu_finish_expected: assert property (@(posedge clk) disable iff (!nRST)
        alu_finish |-> (state == ST_APPEND) || (state == ST_CALC && op_q != OP_MUL));

endmodule

// File: design/calc_top.sv
`timescale 1ns/1ps

module calc_top #(
    parameter int WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [calc_key_pkg::KEY_W-1:0] keypad_input,
    input  logic                           read_input,
    input  calc_arith_pkg::op_t            operator_input,
    input  logic                           equal_input,
    output logic                           busy,
    output logic                           complete,
    output logic [WIDTH-1:0]               display_output
);

    // Controller to add/sub unit
    logic [WIDTH-1:0] alu_a;
    logic [WIDTH-1:0] alu_b;
    logic             alu_sub;
    logic             alu_start;
    logic [WIDTH-1:0] alu_result;
    logic             alu_finish;

    // Controller to multiplier
    logic [WIDTH-1:0] mul_a;
    logic [WIDTH-1:0] mul_b;
    logic             mul_start;
    logic [WIDTH-1:0] mul_result;
    logic             mul_finish;

    calc_controller #(.WIDTH(WIDTH)) u_ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_sub        (alu_sub),
        .alu_start      (alu_start),
        .alu_result     (alu_result),
        .alu_finish     (alu_finish),
        .mul_a          (mul_a),
        .mul_b          (mul_b),
        .mul_start      (mul_start),
        .mul_result     (mul_result),
        .mul_finish     (mul_finish)
    );

    add_sub_unit #(.WIDTH(WIDTH)) u_alu (
        .clk    (clk),
        .nRST   (nRST),
        .a      (alu_a),
        .b      (alu_b),
        .sub    (alu_sub),
        .start  (alu_start),
        .result (alu_result),
        .finish (alu_finish)
    );

    shift_add_multiplier #(.WIDTH(WIDTH)) u_mul (
        .clk    (clk),
        .nRST   (nRST),
        .a      (mul_a),
        .b      (mul_b),
        .start  (mul_start),
        .result (mul_result),
        .finish (mul_finish)
    );

endmodule

// File: dv/calc_checker.sv
`timescale 1ns/1ps

module calc_checker #(
    parameter int WIDTH = 16
) (
    input  logic                           clk,
    input  logic                           nRST,
    input  logic [calc_key_pkg::KEY_W-1:0] keypad_input,
    input  logic                           read_input,
    input  calc_arith_pkg::op_t            operator_input,
    input  logic                           equal_input,
    input  logic                           busy,
    input  logic                           complete,
    input  logic [WIDTH-1:0]               display_output
);
    import calc_arith_pkg::*;
    import calc_key_pkg::*;

    int               errors = 0;
    int               checks = 0;
    logic [WIDTH-1:0] opnd1;
    logic [WIDTH-1:0] opnd2;
    logic [WIDTH-1:0] shown;           // Value the display must hold
    logic [WIDTH-1:0] expected;
    op_t              op_m;
    logic             second;
    logic             pending;
    logic             reset_seen = 1'b0;

    function automatic logic [WIDTH-1:0] apply_op(input op_t op, input logic [WIDTH-1:0] a,
                                                  input logic [WIDTH-1:0] b);
        case (op)
            OP_SUB:  return a - b;       // Two's-complement wrap
            OP_MUL:  return a * b;       // Low word of the product
            default: return a + b;
        endcase
    endfunction

    always @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            opnd1   = '0;
            opnd2   = '0;
            shown   = '0;
            op_m    = OP_ADD;
            second  = 1'b0;
            pending = 1'b0;
        end else begin
            if (complete) begin
                checks++;
                if (!pending) begin
                    errors++;
                    $display("Complete pulse with no calculation pending at %0t", $time);
                end else if (display_output !== expected) begin
                    errors++;
                    $display("FAILED %0t: result %h, expected %h", $time, display_output,
                             expected);
                end
                shown   = display_output;
                pending = 1'b0;
            end else if (display_output !== shown) begin
                errors++;
                $display("FAILED %0t: display changed to %h, expected held %h", $time,
                         display_output, shown);
                shown = display_output;
            end
            if (!busy) begin
                if (equal_input && second) begin
                    expected = apply_op(op_m, opnd1, opnd2);
                    pending  = 1'b1;
                    opnd1    = '0;       // Both operands clear
                    opnd2    = '0;
                    second   = 1'b0;
                end else if (operator_input == OP_ADD || operator_input == OP_SUB ||
                             operator_input == OP_MUL) begin
                    op_m   = operator_input;
                    second = 1'b1;
                end else if (read_input && keypad_input <= MAX_DIGIT) begin
                    if (second) begin
                        opnd2 = opnd2 * RADIX + keypad_input;
                    end else begin
                        opnd1 = opnd1 * RADIX + keypad_input;
                    end
                end
            end
        end
    end

    // First sample after reset falls may still see old outputs
    always @(posedge clk) begin
        if (!nRST) begin
            if (reset_seen && (busy !== 1'b0 || complete !== 1'b0 || display_output !== '0)) begin
                errors++;
                $display("Outputs not cleared while reset is held at %0t", $time);
            end
            reset_seen <= 1'b1;
        end else begin
            reset_seen <= 1'b0;
        end
    end

endmodule

// File: dv/calc_tb.sv
`timescale 1ns/1ps

module calc_tb;
    import calc_arith_pkg::*;
    import calc_key_pkg::*;

    localparam int WIDTH     = 16;
    localparam int LIMIT     = 200;      // Cycles before a wait gives up
    localparam int NUM_CALCS = 60;

    logic             clk;
    logic             nRST;
    logic [KEY_W-1:0] keypad_input;
    logic             read_input;
    op_t              operator_input;
    logic             equal_input;
    logic             busy;
    logic             complete;
    logic [WIDTH-1:0] display_output;

    integer seed = 32'hb7df58dd;
    int     timeouts = 0;
    logic   op_given;                    // Next equal will be accepted
    op_t    bad_ops [5] = '{3'b000, 3'b011, 3'b101, 3'b110, 3'b111};

    calc_top #(.WIDTH(WIDTH)) DUT (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    calc_checker #(.WIDTH(WIDTH)) u_check (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .busy           (busy),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic clear_strobes;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = '0;
        equal_input    = 1'b0;
    endtask

    // Strobes while busy must be dropped
    task automatic drive_noise;
        case (rand_below(8))
            0: begin
                keypad_input = KEY_W'(rand_below(16));
                read_input   = 1'b1;
            end
            1: operator_input = op_t'(3'b001 << rand_below(3));
            2: equal_input = 1'b1;
            default: ;
        endcase
    endtask

    task automatic wait_idle;
        int n;
        n = 0;
        while (busy && n < LIMIT) begin
            drive_noise();
            @(negedge clk);
            clear_strobes();
            n++;
        end
        if (busy) begin
            timeouts++;
            $display("Timeout: busy still high after %0d cycles at %0t", LIMIT, $time);
        end
    endtask

    task automatic wait_complete;
        int n;
        n = 0;
        while (!complete && n < LIMIT) begin
            if (busy) begin
                drive_noise();
            end
            @(negedge clk);
            clear_strobes();
            n++;
        end
        if (!complete) begin
            timeouts++;
            $display("Timeout: no complete pulse within %0d cycles at %0t", LIMIT, $time);
        end
    endtask

    task automatic press_key(input int d);
        keypad_input = KEY_W'(d);
        read_input   = 1'b1;
        @(negedge clk);
        clear_strobes();
        wait_idle();
    endtask

    task automatic press_op(input op_t o);
        operator_input = o;
        @(negedge clk);
        clear_strobes();
        if (o == OP_ADD || o == OP_SUB || o == OP_MUL) begin
            op_given = 1'b1;
        end
        wait_idle();
    endtask

    task automatic press_equal;
        equal_input = 1'b1;
        @(negedge clk);
        clear_strobes();
        if (op_given) begin
            op_given = 1'b0;
            wait_complete();
        end else begin
            wait_idle();
        end
    endtask

    task automatic enter_digits(input int count);
        for (int k = 0; k < count; k++) begin
            if (rand_below(8) == 0) begin
                press_key(10 + rand_below(6));   // Not a digit
            end
            press_key(rand_below(10));
        end
    endtask

    task automatic apply_reset;
        nRST = 1'b0;
        clear_strobes();
        repeat (3) @(negedge clk);
        nRST     = 1'b1;
        op_given = 1'b0;
    endtask

    task automatic run_calc;
        if (rand_below(6) == 0) begin
            press_equal();                       // No operator yet
        end
        enter_digits(rand_below(5) == 0 ? 6 + rand_below(5) : 1 + rand_below(5));
        if (rand_below(6) == 0) begin
            press_op(bad_ops[rand_below(5)]);
        end
        if (rand_below(8) == 0) begin
            press_op(op_t'(3'b001 << rand_below(3)));   // Replaced by the next one
        end
        press_op(op_t'(3'b001 << rand_below(3)));
        enter_digits(rand_below(5) == 0 ? 6 + rand_below(5) : rand_below(6));
        press_equal();
        repeat (rand_below(4)) @(negedge clk);
    endtask

    task automatic reset_during_calc;
        enter_digits(1 + rand_below(3));
        press_op(OP_MUL);
        enter_digits(2);
        equal_input = 1'b1;
        @(negedge clk);
        clear_strobes();
        repeat (3) @(negedge clk);               // Partway through the multiply
        apply_reset();
    endtask

    initial begin
        nRST     = 1'b0;
        op_given = 1'b0;
        clear_strobes();
        repeat (3) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;

        // Small minus large, then an empty second operand
        press_key(1);
        press_key(2);
        press_op(OP_SUB);
        press_key(3);
        press_key(4);
        press_key(5);
        press_equal();
        press_key(7);
        press_op(OP_MUL);
        press_equal();

        for (int i = 0; i < NUM_CALCS && timeouts == 0; i++) begin
            if (i == NUM_CALCS / 2) begin
                reset_during_calc();
            end
            run_calc();
        end
        repeat (5) @(negedge clk);

        $display("Summary: %0d results checked, %0d errors, %0d timeouts",
                 u_check.checks, u_check.errors, timeouts);
        if (u_check.errors == 0 && timeouts == 0 && u_check.checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
design/calc_arith_pkg.sv
design/calc_key_pkg.sv
design/add_sub_unit.sv
design/shift_add_multiplier.sv
design/calc_controller.sv
design/calc_top.sv
dv/calc_checker.sv
dv/calc_tb.sv
